// File: Makefile
# Verilator build and run for the receive subsystem

LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build and run receive_top_tb, fail if the log reports errors"
	@echo "  clean  remove build output and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module receive_top_tb \
		-f flist.f -o receive_top_tb
	./obj_dir/receive_top_tb +verilator+error+limit+1000 | tee $(LOG)
	@if grep -q "Done: errors found" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Done: no errors" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

// File: flist.f
source/receive_pkg.sv
source/sample_differentiator.sv
source/channel_mux.sv
source/sample_discriminator.sv
source/sparse_sample_buffer.sv
source/receive_top.sv
sim/receive_top_properties.sv
sim/receive_top_tb.sv

// File: sim/receive_top_properties.sv
/* receive subsystem properties
   readout handshake and reset checks, bound into receive_top */
`default_nettype none

module receive_top_properties (
  input wire logic                  clk,
  input wire logic                  reset,
  input wire logic                  capture_stop,
  input wire logic                  capturing,
  input wire logic                  overflow,
  input wire logic                  out_valid,
  input wire logic                  out_ready,
  input wire receive_pkg::readout_t out_data
);
  timeunit 1ns;
  timeprecision 100ps;

  // set once the first stop pulse has been seen
  logic stop_seen;
  int assert_failures = 0;

  always_ff @(posedge clk) begin
    if (reset) begin
      stop_seen <= 1'b0;
    end else if (capture_stop) begin
      stop_seen <= 1'b1;
    end
  end

  //////////////////////////////
  // reset and idle
  //////////////////////////////
  assert property (@(posedge clk) reset |=> !out_valid && !capturing && !overflow)
    else begin
      $error("outputs not idle after reset");
      assert_failures++;
    end

  assert property (@(posedge clk) disable iff (reset) !stop_seen |-> !out_valid)
    else begin
      $error("out_valid high before any capture stop");
      assert_failures++;
    end

  //////////////////////////////
  // readout stream
  //////////////////////////////
  assert property (@(posedge clk) disable iff (reset)
      out_valid && !out_ready |=> out_valid && $stable(out_data))
    else begin
      $error("readout word changed while stalled");
      assert_failures++;
    end

  // draining and capturing never overlap
  assert property (@(posedge clk) disable iff (reset) capturing |-> !out_valid)
    else begin
      $error("out_valid high during capture");
      assert_failures++;
    end

endmodule

bind receive_top receive_top_properties props_inst (
  .clk(clk), .reset(reset), .capture_stop(capture_stop), .capturing(capturing),
  .overflow(overflow), .out_valid(out_valid), .out_ready(out_ready), .out_data(out_data)
);

`default_nettype wire

// File: sim/receive_top_tb.sv
/* receive subsystem testbench
   random beats through the chain, checked against a reference model of the readout */
`default_nettype none

module receive_top_tb;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int channels = 2;
  localparam int buffer_depth = 64;
  localparam int clk_period = 4;

  // beat cycles per test, used for the watchdog too
  localparam int cycles_raw = 40;
  localparam int cycles_hyst = 60;
  localparam int cycles_below = 30;
  localparam int cycles_diff = 50;
  localparam int cycles_bp = 60;
  localparam int cycles_ovf = 80;
  localparam int total_cycles =
    cycles_raw + cycles_hyst + cycles_below + cycles_diff + cycles_bp + cycles_ovf;
  // each beat can give up to two words per channel, plus reset and config margin
  localparam int watchdog_ns = total_cycles * 5 * 2 * clk_period + 4000;

  localparam int kind_above = 0;
  localparam int kind_below = 1;
  localparam int kind_straddle = 2;
  localparam int kind_full = 3;

  logic clk = 1'b0;
  logic reset;
  receive_pkg::channel_beat_t [channels-1:0] adc_in;
  receive_pkg::sample_t [channels-1:0] threshold_high;
  receive_pkg::sample_t [channels-1:0] threshold_low;
  logic threshold_load;
  logic [channels-1:0] diff_select;
  logic mux_load;
  logic capture_start;
  logic capture_stop;
  receive_pkg::readout_t out_data;
  logic out_valid;
  logic out_ready;
  logic capturing;
  logic overflow;

  // reference model state
  receive_pkg::sample_t high_val;
  receive_pkg::sample_t low_val;
  logic diff_mode;
  logic in_window;
  logic [channels-1:0] saving;
  logic [channels-1:0] fresh;
  logic [31:0] beat_count [channels];
  receive_pkg::sample_t last_sample [channels];
  receive_pkg::readout_t chan_words [channels][$];
  receive_pkg::readout_t expected [$];

  logic [31:0] rnd_state = 32'hba2d_e65a;
  logic [31:0] ready_state;
  logic random_ready;

  string test_name;
  int test_errors;
  int tests_run;
  int tests_failed;
  int total_errors;

  receive_top #(.channels(channels), .buffer_depth(buffer_depth)) receive_top_inst (
    .clk, .reset, .adc_in, .threshold_high, .threshold_low, .threshold_load,
    .diff_select, .mux_load, .capture_start, .capture_stop,
    .out_data, .out_valid, .out_ready, .capturing, .overflow
  );

  always #(clk_period / 2) clk = ~clk;

  //////////////////////////////
  // random numbers
  //////////////////////////////
  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_random();
    rnd_state = xorshift(rnd_state);
    return rnd_state;
  endfunction

  function automatic receive_pkg::sample_t make_sample(input int kind);
    logic [31:0] r;
    r = next_random();
    case (kind)
      kind_above: return receive_pkg::sample_t'(1001 + int'(r % 8000));
      kind_below: return receive_pkg::sample_t'(-1001 - int'(r % 8000));
      kind_straddle: return receive_pkg::sample_t'(int'(r % 6000) - 3000);
      default: return receive_pkg::sample_t'(r[15:0]);
    endcase
  endfunction

  //////////////////////////////
  // reference model
  //////////////////////////////
  // floor of half the signed difference
  function automatic receive_pkg::sample_t halve_diff(input receive_pkg::sample_t cur,
                                                      input receive_pkg::sample_t prev);
    int d;
    d = int'(cur) - int'(prev);
    d = d >>> 1;
    return receive_pkg::sample_t'(d);
  endfunction

  function automatic void model_beat(input int ch, input receive_pkg::sample_beat_t data);
    receive_pkg::sample_beat_t seen;
    receive_pkg::sample_t prev;
    logic any_above;
    logic all_below;
    logic keep;
    receive_pkg::readout_t w;
    any_above = 1'b0;
    all_below = 1'b1;
    prev = last_sample[ch];
    for (int lane = 0; lane < receive_pkg::parallel_samples; lane++) begin
      seen[lane] = diff_mode ? halve_diff(data[lane], prev) : data[lane];
      prev = data[lane];
      if (seen[lane] > high_val) any_above = 1'b1;
      if (!(seen[lane] < low_val)) all_below = 1'b0;
    end
    last_sample[ch] = data[receive_pkg::parallel_samples-1];
    keep = saving[ch] ? !all_below : any_above;
    if (in_window && keep) begin
      w.channel = ch[0];
      if (!saving[ch] || fresh[ch]) begin
        w.word.is_timestamp = 1'b1;
        w.word.payload.timestamp = beat_count[ch];
        chan_words[ch].push_back(w);
      end
      w.word.is_timestamp = 1'b0;
      w.word.payload.samples = seen;
      chan_words[ch].push_back(w);
    end
    if (keep) fresh[ch] = 1'b0;
    saving[ch] = keep;
    beat_count[ch] = beat_count[ch] + 1;
  endfunction

  //////////////////////////////
  // checks
  //////////////////////////////
  task automatic check_value(input string what, input logic [63:0] exp_val,
                             input logic [63:0] act_val);
    if (exp_val !== act_val) begin
      $display("Fail %s expected %0h actual %0h", what, exp_val, act_val);
      test_errors++;
    end
  endtask

  // every word taken on the stream must be the next expected one
  always @(posedge clk) begin
    receive_pkg::readout_t exp_word;
    if (!reset && out_valid && out_ready) begin
      if (expected.size() == 0) begin
        $display("%s: extra readout word %0h after the expected ones", test_name, out_data);
        test_errors++;
      end else begin
        exp_word = expected.pop_front();
        if (out_data !== exp_word) begin
          $display("Fail %s expected %0h actual %0h", test_name, exp_word, out_data);
          test_errors++;
        end
      end
    end
  end

  always @(posedge clk) begin
    ready_state <= xorshift(ready_state);
    out_ready <= random_ready ? ready_state[7] : 1'b1;
  end

  //////////////////////////////
  // stimulus
  //////////////////////////////
  task automatic send_beats(input int cycles, input int kind, input logic gaps);
    receive_pkg::channel_beat_t [channels-1:0] beat;
    logic [31:0] r;
    for (int n = 0; n < cycles; n++) begin
      for (int ch = 0; ch < channels; ch++) begin
        r = next_random();
        beat[ch].valid = gaps ? (r[1:0] != 2'b00) : 1'b1;
        for (int lane = 0; lane < receive_pkg::parallel_samples; lane++) begin
          beat[ch].data[lane] = make_sample(kind);
        end
        if (beat[ch].valid) model_beat(ch, beat[ch].data);
      end
      @(posedge clk);
      adc_in <= beat;
    end
    @(posedge clk);
    adc_in <= '0;
  endtask

  task automatic finish_test();
    tests_run++;
    total_errors += test_errors;
    if (test_errors != 0) tests_failed++;
    $display("%s: %s, %0d errors", test_name, (test_errors == 0) ? "passed" : "failed",
             test_errors);
  endtask

  task automatic run_capture(input string name, input int cycles, input int kind,
                             input logic gaps);
    int limit;
    int n;
    logic exp_overflow;
    logic start_tried;
    test_name = name;
    test_errors = 0;
    exp_overflow = 1'b0;
    start_tried = 1'b0;
    @(posedge clk);
    capture_start <= 1'b1;
    fresh = '1;
    in_window = 1'b1;
    @(posedge clk);
    capture_start <= 1'b0;
    send_beats(cycles, kind, gaps);
    repeat (2) @(posedge clk);
    in_window = 1'b0;
    capture_stop <= 1'b1;
    @(posedge clk);
    capture_stop <= 1'b0;
    for (int ch = 0; ch < channels; ch++) begin
      if (chan_words[ch].size() > buffer_depth) exp_overflow = 1'b1;
      for (int i = 0; i < chan_words[ch].size() && i < buffer_depth; i++) begin
        expected.push_back(chan_words[ch][i]);
      end
      chan_words[ch].delete();
    end
    limit = 4 * expected.size() + 64;
    for (n = 0; n < limit; n++) begin
      @(posedge clk);
      // a start while readout is still busy must be ignored
      if (!start_tried && out_valid && expected.size() > 8) begin
        capture_start <= 1'b1;
        start_tried = 1'b1;
      end else begin
        capture_start <= 1'b0;
      end
      if (n > 8 && expected.size() == 0 && !out_valid) break;
    end
    // room for the drain to reach idle and for any stray word to show
    repeat (8) @(posedge clk);
    if (expected.size() != 0) begin
      $display("%s: %0d readout words never arrived", name, expected.size());
      test_errors++;
      expected.delete();
    end
    check_value({name, " overflow"}, 64'(exp_overflow), 64'(overflow));
    finish_test();
  endtask

  task automatic load_thresholds(input receive_pkg::sample_t high, input receive_pkg::sample_t low);
    @(posedge clk);
    threshold_high <= {channels{high}};
    threshold_low <= {channels{low}};
    threshold_load <= 1'b1;
    @(posedge clk);
    threshold_load <= 1'b0;
    high_val = high;
    low_val = low;
    repeat (4) @(posedge clk);
  endtask

  task automatic select_stream(input logic use_diff);
    @(posedge clk);
    diff_select <= {channels{use_diff}};
    mux_load <= 1'b1;
    @(posedge clk);
    mux_load <= 1'b0;
    diff_mode = use_diff;
    repeat (4) @(posedge clk);
  endtask

  initial begin
    #(watchdog_ns * 1ns);
    $display("watchdog expired before the tests finished");
    $display("Done: errors found");
    $finish;
  end

  initial begin
    reset = 1'b1;
    adc_in = '0;
    threshold_high = '0;
    threshold_low = '0;
    threshold_load = 1'b0;
    diff_select = '0;
    mux_load = 1'b0;
    capture_start = 1'b0;
    capture_stop = 1'b0;
    out_ready = 1'b1;
    random_ready = 1'b0;
    ready_state = xorshift(32'hba2d_e65a);
    diff_mode = 1'b0;
    in_window = 1'b0;
    saving = '0;
    fresh = '0;
    high_val = '0;
    low_val = '0;
    for (int ch = 0; ch < channels; ch++) begin
      beat_count[ch] = 0;
      last_sample[ch] = '0;
    end
    tests_run = 0;
    tests_failed = 0;
    total_errors = 0;

    repeat (16) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    test_name = "after_reset";
    test_errors = 0;
    check_value("after_reset out_valid", 64'(0), 64'(out_valid));
    check_value("after_reset capturing", 64'(0), 64'(capturing));
    check_value("after_reset overflow", 64'(0), 64'(overflow));
    finish_test();

    load_thresholds(16'sd1000, -16'sd1000);
    run_capture("raw_above", cycles_raw, kind_above, 1'b1);
    run_capture("hysteresis_straddle", cycles_hyst, kind_straddle, 1'b1);
    run_capture("hysteresis_below", cycles_below, kind_below, 1'b1);

    select_stream(1'b1);
    run_capture("differentiated", cycles_diff, kind_full, 1'b1);

    random_ready <= 1'b1;
    run_capture("back_pressure", cycles_bp, kind_straddle, 1'b1);
    random_ready <= 1'b0;

    select_stream(1'b0);
    run_capture("overflow", cycles_ovf, kind_above, 1'b0);

    total_errors += receive_top_inst.props_inst.assert_failures;
    $display("tests %0d, failed %0d, errors %0d, assertion failures %0d",
             tests_run, tests_failed, total_errors,
             receive_top_inst.props_inst.assert_failures);
    if (total_errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: source/channel_mux.sv
/* channel mux
   picks the raw or differentiated stream per channel from a latched select */
`default_nettype none

module channel_mux #(
  parameter int channels = 2
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset,
  input  wire receive_pkg::channel_beat_t [channels-1:0] raw_in,
  input  wire receive_pkg::channel_beat_t [channels-1:0] diff_in,
  input  wire logic [channels-1:0]                       diff_select,
  input  wire logic                                      select_load,
  output receive_pkg::channel_beat_t [channels-1:0]      mux_out
);

  // 1 picks the differentiated stream
  logic [channels-1:0] select_q;

  logic [channels-1:0] valid_q;
  receive_pkg::sample_beat_t [channels-1:0] data_q;

  // the beat sampled on the load edge still sees the old select
  always_ff @(posedge clk) begin
    if (reset) begin
      select_q <= '0;
      valid_q <= '0;
    end else begin
      if (select_load) begin
        select_q <= diff_select;
      end
      for (int ch = 0; ch < channels; ch++) begin
        valid_q[ch] <= select_q[ch] ? diff_in[ch].valid : raw_in[ch].valid;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      data_q[ch] <= select_q[ch] ? diff_in[ch].data : raw_in[ch].data;
    end
  end

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      mux_out[ch].valid = valid_q[ch];
      mux_out[ch].data = data_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: source/receive_pkg.sv
/* receive subsystem shared types
   sample beats, per-stage channel words and the sparse buffer word */
`default_nettype none

package receive_pkg;

  //////////////////////////////
  // sizes
  //////////////////////////////
  localparam int sample_width = 16;
  localparam int parallel_samples = 2;
  localparam int timestamp_width = 32;

  // channel count the readout index is sized for
  localparam int default_channels = 2;
  localparam int channel_index_width = $clog2(default_channels);

  //////////////////////////////
  // sample data
  //////////////////////////////
  typedef logic signed [sample_width-1:0] sample_t;

  // lane 0 is the oldest sample of the beat
  typedef sample_t [parallel_samples-1:0] sample_beat_t;

  // one channel's beat between pipeline stages
  typedef struct packed {
    logic         valid;
    sample_beat_t data;
  } channel_beat_t;

  // discriminator result for one channel
  typedef struct packed {
    logic                       keep;
    logic                       run_start;
    logic [timestamp_width-1:0] timestamp;
    sample_beat_t               data;
  } kept_beat_t;

  //////////////////////////////
  // buffer words
  //////////////////////////////
  // a stored word holds either the start time of a run or one beat
  typedef union packed {
    logic [timestamp_width-1:0] timestamp;
    sample_beat_t               samples;
  } buffer_payload_u;

  typedef struct packed {
    logic            is_timestamp;
    buffer_payload_u payload;
  } buffer_word_t;

  // word on the readout stream, tagged with its source channel
  typedef struct packed {
    logic [channel_index_width-1:0] channel;
    buffer_word_t                   word;
  } readout_t;

endpackage

`default_nettype wire

// File: source/receive_top.sv
/* receive subsystem top
   differentiator, channel mux, discriminator and sparse buffer in a chain */
`default_nettype none

module receive_top #(
  parameter int channels = receive_pkg::default_channels,
  parameter int buffer_depth = 64
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset,
  input  wire receive_pkg::channel_beat_t [channels-1:0] adc_in,
  input  wire receive_pkg::sample_t [channels-1:0]       threshold_high,
  input  wire receive_pkg::sample_t [channels-1:0]       threshold_low,
  input  wire logic                                      threshold_load,
  input  wire logic [channels-1:0]                       diff_select,
  input  wire logic                                      mux_load,
  input  wire logic                                      capture_start,
  input  wire logic                                      capture_stop,
  output receive_pkg::readout_t                          out_data,
  output logic                                           out_valid,
  input  wire logic                                      out_ready,
  output logic                                           capturing,
  output logic                                           overflow
);

  // registered configuration
  logic threshold_load_q;
  logic mux_load_q;
  receive_pkg::sample_t [channels-1:0] threshold_high_q;
  receive_pkg::sample_t [channels-1:0] threshold_low_q;
  logic [channels-1:0] diff_select_q;

  // capture pulses, 3 deep to match the datapath
  logic [2:0] start_pipe;
  logic [2:0] stop_pipe;

  receive_pkg::channel_beat_t [channels-1:0] raw_beats;
  receive_pkg::channel_beat_t [channels-1:0] diff_beats;
  receive_pkg::channel_beat_t [channels-1:0] mux_beats;
  receive_pkg::kept_beat_t [channels-1:0] kept_beats;

  always_ff @(posedge clk) begin
    if (reset) begin
      threshold_load_q <= 1'b0;
      mux_load_q <= 1'b0;
      start_pipe <= '0;
      stop_pipe <= '0;
    end else begin
      threshold_load_q <= threshold_load;
      mux_load_q <= mux_load;
      start_pipe <= {start_pipe[1:0], capture_start};
      stop_pipe <= {stop_pipe[1:0], capture_stop};
    end
  end

  always_ff @(posedge clk) begin
    threshold_high_q <= threshold_high;
    threshold_low_q <= threshold_low;
    diff_select_q <= diff_select;
  end

  sample_differentiator #(.channels(channels)) differentiator_inst (
    .clk, .reset, .adc_in, .raw_out(raw_beats), .diff_out(diff_beats)
  );

  channel_mux #(.channels(channels)) mux_inst (
    .clk, .reset, .raw_in(raw_beats), .diff_in(diff_beats),
    .diff_select(diff_select_q), .select_load(mux_load_q), .mux_out(mux_beats)
  );

  // the arm reaches the discriminator one stage ahead of the buffer
  sample_discriminator #(.channels(channels)) discriminator_inst (
    .clk, .reset, .beat_in(mux_beats),
    .threshold_high(threshold_high_q), .threshold_low(threshold_low_q),
    .threshold_load(threshold_load_q), .capture_arm(start_pipe[1]), .kept_out(kept_beats)
  );

  sparse_sample_buffer #(.channels(channels), .buffer_depth(buffer_depth)) buffer_inst (
    .clk, .reset, .kept_in(kept_beats),
    .capture_start(start_pipe[2]), .capture_stop(stop_pipe[2]),
    .capturing, .overflow, .out_data, .out_valid, .out_ready
  );

endmodule

`default_nettype wire

// File: source/sample_differentiator.sv
/* sample differentiator
   registers each raw beat next to its halved first difference */
`default_nettype none

module sample_differentiator #(
  parameter int channels = 2
) (
  input  wire logic                                        clk,
  input  wire logic                                        reset,
  input  wire receive_pkg::channel_beat_t [channels-1:0]   adc_in,
  output receive_pkg::channel_beat_t [channels-1:0]        raw_out,
  output receive_pkg::channel_beat_t [channels-1:0]        diff_out
);

  // last sample of the previous valid beat, per channel
  receive_pkg::sample_t [channels-1:0] last_sample;

  logic [channels-1:0] valid_q;
  receive_pkg::sample_beat_t [channels-1:0] raw_q;
  receive_pkg::sample_beat_t [channels-1:0] diff_q;
  receive_pkg::sample_beat_t [channels-1:0] diff_next;

  always_comb begin
    receive_pkg::sample_t [receive_pkg::parallel_samples:0] ext;
    logic signed [receive_pkg::sample_width:0] delta;
    for (int ch = 0; ch < channels; ch++) begin
      // ext[i] is the sample just before lane i
      ext = {adc_in[ch].data, last_sample[ch]};
      for (int lane = 0; lane < receive_pkg::parallel_samples; lane++) begin
        // one extra bit so the halved difference never wraps
        delta = ext[lane+1] - ext[lane];
        diff_next[ch][lane] = delta[receive_pkg::sample_width:1];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      valid_q <= '0;
      last_sample <= '0;
    end else begin
      for (int ch = 0; ch < channels; ch++) begin
        valid_q[ch] <= adc_in[ch].valid;
        if (adc_in[ch].valid) begin
          last_sample[ch] <= adc_in[ch].data[receive_pkg::parallel_samples-1];
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      raw_q[ch] <= adc_in[ch].data;
    end
    diff_q <= diff_next;
  end

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      raw_out[ch].valid = valid_q[ch];
      raw_out[ch].data = raw_q[ch];
      diff_out[ch].valid = valid_q[ch];
      diff_out[ch].data = diff_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: source/sample_discriminator.sv
/* sample discriminator
   hysteresis gate per channel with beat counter and run start flag */
`default_nettype none

module sample_discriminator #(
  parameter int channels = 2
) (
  input  wire logic                                      clk,
  input  wire logic                                      reset,
  input  wire receive_pkg::channel_beat_t [channels-1:0] beat_in,
  input  wire receive_pkg::sample_t [channels-1:0]       threshold_high,
  input  wire receive_pkg::sample_t [channels-1:0]       threshold_low,
  input  wire logic                                      threshold_load,
  input  wire logic                                      capture_arm,
  output receive_pkg::kept_beat_t [channels-1:0]         kept_out
);

  receive_pkg::sample_t [channels-1:0] high_q;
  receive_pkg::sample_t [channels-1:0] low_q;

  // saving also means the last valid beat was kept
  logic [channels-1:0] saving;
  // armed but no beat kept yet since the arm
  logic [channels-1:0] arm_fresh;
  logic arm_q;
  logic arm_rise;

  logic [channels-1:0][receive_pkg::timestamp_width-1:0] count;

  logic [channels-1:0] keep_now;
  logic [channels-1:0] start_now;

  logic [channels-1:0] keep_q;
  logic [channels-1:0] run_start_q;
  logic [channels-1:0][receive_pkg::timestamp_width-1:0] stamp_q;
  receive_pkg::sample_beat_t [channels-1:0] data_q;

  assign arm_rise = capture_arm && !arm_q;

  //////////////////////////////
  // keep decision
  //////////////////////////////
  always_comb begin
    logic any_above;
    logic all_below;
    for (int ch = 0; ch < channels; ch++) begin
      any_above = 1'b0;
      all_below = 1'b1;
      for (int lane = 0; lane < receive_pkg::parallel_samples; lane++) begin
        if ($signed(beat_in[ch].data[lane]) > $signed(high_q[ch])) begin
          any_above = 1'b1;
        end
        if (!($signed(beat_in[ch].data[lane]) < $signed(low_q[ch]))) begin
          all_below = 1'b0;
        end
      end
      // while saving only an all-low beat ends the run, and is dropped
      keep_now[ch] = beat_in[ch].valid && (saving[ch] ? !all_below : any_above);
      start_now[ch] = keep_now[ch] && (!saving[ch] || arm_fresh[ch] || arm_rise);
    end
  end

  //////////////////////////////
  // state and counters
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      arm_q <= 1'b0;
      saving <= '0;
      arm_fresh <= '0;
      count <= '0;
      keep_q <= '0;
      run_start_q <= '0;
    end else begin
      arm_q <= capture_arm;
      for (int ch = 0; ch < channels; ch++) begin
        keep_q[ch] <= keep_now[ch];
        run_start_q[ch] <= start_now[ch];
        if (beat_in[ch].valid) begin
          saving[ch] <= keep_now[ch];
          count[ch] <= count[ch] + 1'b1;
        end
        if (keep_now[ch]) begin
          arm_fresh[ch] <= 1'b0;
        end else if (arm_rise) begin
          arm_fresh[ch] <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (threshold_load) begin
      high_q <= threshold_high;
      low_q <= threshold_low;
    end
    // count before this beat, i.e. its index since reset
    stamp_q <= count;
    for (int ch = 0; ch < channels; ch++) begin
      data_q[ch] <= beat_in[ch].data;
    end
  end

  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      kept_out[ch].keep = keep_q[ch];
      kept_out[ch].run_start = run_start_q[ch];
      kept_out[ch].timestamp = stamp_q[ch];
      kept_out[ch].data = data_q[ch];
    end
  end

endmodule

`default_nettype wire

// File: source/sparse_sample_buffer.sv
/* sparse sample buffer
   stores kept runs per channel, then drains them channel by channel */
`default_nettype none

module sparse_sample_buffer #(
  parameter int channels = 2,
  parameter int buffer_depth = 64
) (
  input  wire logic                                   clk,
  input  wire logic                                   reset,
  input  wire receive_pkg::kept_beat_t [channels-1:0] kept_in,
  input  wire logic                                   capture_start,
  input  wire logic                                   capture_stop,
  output logic                                        capturing,
  output logic                                        overflow,
  output receive_pkg::readout_t                       out_data,
  output logic                                        out_valid,
  input  wire logic                                   out_ready
);

  localparam int addr_width = $clog2(buffer_depth);
  localparam int count_width = addr_width + 1;

  typedef enum logic [1:0] {st_idle, st_capture, st_drain} state_t;
  state_t state;

  receive_pkg::buffer_word_t mem [channels][buffer_depth];

  logic [channels-1:0][count_width-1:0] wr_count;
  logic [channels-1:0][count_width-1:0] wr_base;
  logic [channels-1:0] full;
  logic [channels-1:0] take;
  logic [channels-1:0] wr_en;
  logic [channels-1:0] fill_pend;
  receive_pkg::buffer_word_t [channels-1:0] ts_word;
  receive_pkg::buffer_word_t [channels-1:0] data_word;
  receive_pkg::buffer_word_t [channels-1:0] wr_word;

  // holds the beat behind a timestamp word
  logic [channels-1:0] pend_valid;
  receive_pkg::buffer_word_t [channels-1:0] pend_word;

  logic start_now;
  logic accept;
  logic [receive_pkg::channel_index_width-1:0] rd_ch;
  logic [count_width-1:0] rd_addr;
  logic drain_step;
  logic has_word;

  assign capturing = (state == st_capture);
  assign start_now = (state == st_idle) && capture_start;
  // the beat that lines up with the stop is not stored
  assign accept = start_now || ((state == st_capture) && !capture_stop);

  assign drain_step = (state == st_drain) && (!out_valid || out_ready);
  assign has_word = rd_addr < wr_count[rd_ch];

  //////////////////////////////
  // write side
  //////////////////////////////
  always_comb begin
    for (int ch = 0; ch < channels; ch++) begin
      ts_word[ch].is_timestamp = 1'b1;
      ts_word[ch].payload.timestamp = kept_in[ch].timestamp;
      data_word[ch].is_timestamp = 1'b0;
      data_word[ch].payload.samples = kept_in[ch].data;
      wr_base[ch] = start_now ? '0 : wr_count[ch];
      full[ch] = (wr_base[ch] == count_width'(buffer_depth));
      take[ch] = accept && kept_in[ch].keep;
      // pending drains first; a run start needs a gap, so it never meets a full pending
      wr_en[ch] = pend_valid[ch] || take[ch];
      if (pend_valid[ch]) begin
        wr_word[ch] = pend_word[ch];
      end else if (kept_in[ch].run_start) begin
        wr_word[ch] = ts_word[ch];
      end else begin
        wr_word[ch] = data_word[ch];
      end
      fill_pend[ch] = take[ch] && (pend_valid[ch] || kept_in[ch].run_start);
    end
  end

  always_ff @(posedge clk) begin
    for (int ch = 0; ch < channels; ch++) begin
      if (wr_en[ch] && !full[ch]) begin
        mem[ch][wr_base[ch][addr_width-1:0]] <= wr_word[ch];
      end
      pend_word[ch] <= data_word[ch];
    end
  end

  //////////////////////////////
  // control and drain
  //////////////////////////////
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= st_idle;
      wr_count <= '0;
      pend_valid <= '0;
      overflow <= 1'b0;
      rd_ch <= '0;
      rd_addr <= '0;
      out_valid <= 1'b0;
    end else begin
      if (start_now) begin
        overflow <= 1'b0;
      end
      for (int ch = 0; ch < channels; ch++) begin
        pend_valid[ch] <= fill_pend[ch];
        if (wr_en[ch] && full[ch]) begin
          overflow <= 1'b1;
          wr_count[ch] <= wr_base[ch];
        end else if (wr_en[ch]) begin
          wr_count[ch] <= wr_base[ch] + 1'b1;
        end else begin
          wr_count[ch] <= wr_base[ch];
        end
      end
      case (state)
        st_idle: begin
          if (capture_start) state <= st_capture;
        end
        st_capture: begin
          if (capture_stop) begin
            state <= st_drain;
            rd_ch <= '0;
            rd_addr <= '0;
          end
        end
        default: begin
          if (drain_step) begin
            if (has_word) begin
              out_valid <= 1'b1;
              rd_addr <= rd_addr + 1'b1;
            end else begin
              out_valid <= 1'b0;
              rd_addr <= '0;
              if (rd_ch == receive_pkg::channel_index_width'(channels - 1)) begin
                state <= st_idle;
              end else begin
                rd_ch <= rd_ch + 1'b1;
              end
            end
          end
        end
      endcase
    end
  end

  // output word holds until it is taken
  always_ff @(posedge clk) begin
    if (drain_step && has_word) begin
      out_data.channel <= rd_ch;
      out_data.word <= mem[rd_ch][rd_addr[addr_width-1:0]];
    end
  end

endmodule

`default_nettype wire
